// File: logic/icache_pkg.sv
package icache_pkg;

    // fixed widths of the fetch path
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned BYTE_OFF_W = 2;     // byte offset inside one word

    typedef logic [ADDR_W-1:0] addr_t;          // byte address
    typedef logic [WORD_W-1:0] word_t;          // instruction word

    // fetch request, held by the CPU while cpu_req is high
    typedef struct packed {
        addr_t pc;
        logic  uncached;                        // bypass the arrays
    } fetch_req_t;

    // fetch response, valid while cpu_ack is high
    typedef struct packed {
        word_t data;
        logic  adef;                            // misaligned pc
    } fetch_rsp_t;

    // read request to the memory port
    typedef struct packed {
        addr_t addr;                            // line or word aligned
        logic  single;                          // one word, not a whole line
    } mem_rd_t;

endpackage

// File: logic/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int unsigned SETS       = 64,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned IDX_W = $clog2(SETS),
    localparam int unsigned OFF_W = $clog2(LINE_WORDS) + icache_pkg::BYTE_OFF_W,
    localparam int unsigned TAG_W = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_index,
    input  logic [TAG_W-1:0] rd_tag,
    input  logic             wr_en,
    input  logic [1:0]       wr_way,
    input  logic [IDX_W-1:0] wr_index,
    input  logic [TAG_W-1:0] wr_tag,
    input  logic             clr_en,
    input  logic [IDX_W-1:0] clr_index,
    output logic [1:0]       hit
);

    typedef logic [TAG_W-1:0] tag_t;

    tag_t            tags [2][SETS];
    logic [SETS-1:0] valid [2];
    tag_t            tag_q [2];                 // tags read at the lookup edge
    tag_t            cmp_tag_q;                 // tag of the looked-up pc
    logic [1:0]      valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid[0] <= '0;
            valid[1] <= '0;
            valid_q  <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (clr_en) valid[w][clr_index] <= 1'b0;    // flush sweep
                else if (wr_en && wr_way[w]) valid[w][wr_index] <= 1'b1;
                if (rd_en) valid_q[w] <= valid[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_en && wr_way[w]) tags[w][wr_index] <= wr_tag;
            if (rd_en) tag_q[w] <= tags[w][rd_index];
        end
        if (rd_en) cmp_tag_q <= rd_tag;
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag_q);
        end
    end

    // a line is only ever filled into one way, so both ways never match
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) !(&hit))
        else $error("tag array: line present in both ways");

endmodule

// File: logic/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array #(
    parameter int unsigned SETS       = 64,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned IDX_W = $clog2(SETS)
) (
    input  logic                                  clk,
    input  logic                                  rd_en,
    input  logic [IDX_W-1:0]                      rd_index,
    input  logic                                  wr_en,
    input  logic [1:0]                            wr_way,
    input  logic [IDX_W-1:0]                      wr_index,
    input  icache_pkg::word_t [LINE_WORDS-1:0]    wr_line,
    output icache_pkg::word_t [LINE_WORDS-1:0]    rd_line0,
    output icache_pkg::word_t [LINE_WORDS-1:0]    rd_line1
);

    typedef icache_pkg::word_t [LINE_WORDS-1:0] line_t;

    line_t mem0 [SETS];     // way 0 lines
    line_t mem1 [SETS];     // way 1 lines

    always_ff @(posedge clk) begin
        if (wr_en && wr_way[0]) mem0[wr_index] <= wr_line;
        if (wr_en && wr_way[1]) mem1[wr_index] <= wr_line;
    end

    // both ways read together, word pick happens in the controller
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line0 <= mem0[rd_index];
            rd_line1 <= mem1[rd_index];
        end
    end

endmodule

// File: logic/icache_refill_buffer.sv
`timescale 1ns/1ps

module icache_refill_buffer #(
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic                                  rvalid,
    input  logic                                  rlast,
    input  icache_pkg::word_t                     rdata,
    output icache_pkg::word_t [LINE_WORDS-1:0]    line,
    output icache_pkg::word_t                     first_word,
    output logic                                  fill_done
);

    logic [CNT_W-1:0] cnt;      // position of the next beat
    logic             active;   // refill in progress

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            active    <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= rvalid && rlast;   // one cycle after the last beat
            if (start) begin
                cnt    <= '0;
                active <= 1'b1;
            end else if (rvalid) begin
                cnt <= cnt + 1'b1;
                if (rlast) active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid) line[cnt] <= rdata;
    end

    assign first_word = line[0];    // single-word fetch lands here

    a_beat_expected: assert property (@(posedge clk) disable iff (rst) rvalid |-> active)
        else $error("refill buffer: return beat without a request");

    a_last_in_time: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rlast |-> cnt != CNT_W'(LINE_WORDS - 1))
        else $error("refill buffer: no rlast by the end of the line");

endmodule

// File: logic/icache_lru.sv
`timescale 1ns/1ps

module icache_lru #(
    parameter int unsigned SETS = 64,
    localparam int unsigned IDX_W = $clog2(SETS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [IDX_W-1:0] index,
    input  logic             touch,
    input  logic [1:0]       touch_way,
    input  logic             clr_en,
    input  logic [IDX_W-1:0] clr_index,
    output logic [1:0]       victim
);

    logic [SETS-1:0] lru;   // 1 means way 1 is least recently used

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (clr_en) begin
            lru[clr_index] <= 1'b0;
        end else if (touch) begin
            lru[index] <= touch_way[0];     // point at the other way
        end
    end

    // fills go way 0 first after a clear, so an empty way is picked first
    assign victim = lru[index] ? 2'b10 : 2'b01;

endmodule

// File: logic/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int unsigned SETS       = 64,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned WOFF_W = $clog2(LINE_WORDS),
    localparam int unsigned OFF_W  = WOFF_W + icache_pkg::BYTE_OFF_W,
    localparam int unsigned IDX_W  = $clog2(SETS),
    localparam int unsigned TAG_W  = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cpu_req,
    input  icache_pkg::fetch_req_t                fetch,
    output logic                                  cpu_ack,
    output icache_pkg::fetch_rsp_t                rsp,
    input  logic                                  flush_req,
    output logic                                  flush_ack,
    output logic                                  mem_req,
    output icache_pkg::mem_rd_t                   mem_rd,
    input  logic                                  mem_accept,
    output logic                                  rd_en,
    output logic [IDX_W-1:0]                      rd_index,
    output logic [TAG_W-1:0]                      rd_tag,
    input  logic [1:0]                            hit,
    input  icache_pkg::word_t [LINE_WORDS-1:0]    rd_line0,
    input  icache_pkg::word_t [LINE_WORDS-1:0]    rd_line1,
    output logic                                  fill_start,
    input  icache_pkg::word_t [LINE_WORDS-1:0]    fill_line,
    input  icache_pkg::word_t                     first_word,
    input  logic                                  fill_done,
    output logic                                  wr_en,
    output logic [1:0]                            wr_way,
    output logic [IDX_W-1:0]                      wr_index,
    output logic [TAG_W-1:0]                      wr_tag,
    output logic                                  clr_en,
    output logic [IDX_W-1:0]                      clr_index,
    output logic                                  lru_touch,
    output logic [1:0]                            lru_way,
    input  logic [1:0]                            victim
);

    localparam int unsigned ADDR_W = icache_pkg::ADDR_W;
    localparam int unsigned BOFF_W = icache_pkg::BYTE_OFF_W;

    typedef logic [IDX_W-1:0]  index_t;
    typedef logic [WOFF_W-1:0] woff_t;
    typedef enum logic [2:0] {IDLE, LOOKUP, MISS_REQ, MISS_WAIT, RESPOND, FLUSH, DONE} state_t;

    state_t                 state;
    icache_pkg::fetch_req_t req_q;      // fetch being served
    icache_pkg::fetch_rsp_t rsp_q;
    icache_pkg::fetch_rsp_t fill_rsp;
    logic [1:0]             victim_q;   // way chosen at lookup
    index_t                 flush_cnt;
    index_t                 req_index;
    woff_t                  req_woff;
    logic                   misaligned;
    logic                   cached_hit;
    logic                   go_mem;

    assign req_index  = req_q.pc[OFF_W +: IDX_W];
    assign req_woff   = req_q.pc[BOFF_W +: WOFF_W];
    assign misaligned = req_q.pc[BOFF_W-1:0] != '0;
    assign cached_hit = !req_q.uncached && (|hit);
    assign go_mem     = (state == LOOKUP) && !misaligned && !cached_hit;

    // arrays are read on the edge that sees the request
    assign rd_en    = (state == IDLE) && cpu_req && !flush_req;
    assign rd_index = (state == IDLE) ? fetch.pc[OFF_W +: IDX_W] : req_index;
    assign rd_tag   = fetch.pc[ADDR_W-1 -: TAG_W];

    assign fill_start = go_mem;
    assign mem_req    = (state == MISS_REQ);
    assign mem_rd.single = req_q.uncached;
    assign mem_rd.addr   = req_q.uncached ? {req_q.pc[ADDR_W-1:BOFF_W], {BOFF_W{1'b0}}}
                                          : {req_q.pc[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    assign fill_rsp.data = req_q.uncached ? first_word : fill_line[req_woff];
    assign fill_rsp.adef = 1'b0;

    // line write in the cycle the refill completes
    assign wr_en    = (state == MISS_WAIT) && fill_done && !req_q.uncached;
    assign wr_way   = victim_q;
    assign wr_index = req_index;
    assign wr_tag   = req_q.pc[ADDR_W-1 -: TAG_W];

    assign clr_en    = (state == FLUSH);
    assign clr_index = flush_cnt;

    assign lru_touch = ((state == LOOKUP) && !misaligned && cached_hit) || wr_en;
    assign lru_way   = (state == LOOKUP) ? hit : victim_q;

    assign cpu_ack   = (state == RESPOND) || ((state == MISS_WAIT) && fill_done);
    assign rsp       = (state == MISS_WAIT) ? fill_rsp : rsp_q;
    assign flush_ack = (state == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (flush_req) begin            // flush wins over fetch
                        state     <= FLUSH;
                        flush_cnt <= '0;
                    end else if (cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: state <= go_mem ? MISS_REQ : RESPOND;
                MISS_REQ: begin
                    if (mem_accept) state <= MISS_WAIT;
                end
                MISS_WAIT: begin
                    if (fill_done) state <= RESPOND;
                end
                RESPOND: begin
                    if (!cpu_req) state <= IDLE;    // hold ack until req drops
                end
                FLUSH: begin
                    if (flush_cnt == index_t'(SETS - 1)) state <= DONE;
                    else flush_cnt <= flush_cnt + 1'b1;
                end
                DONE: begin
                    if (!flush_req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) req_q <= fetch;
        if (state == LOOKUP) begin
            victim_q   <= victim;
            rsp_q.adef <= misaligned;
            rsp_q.data <= hit[1] ? rd_line1[req_woff] : rd_line0[req_woff];
        end
        if ((state == MISS_WAIT) && fill_done) rsp_q <= fill_rsp;
    end

    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_accept |=> mem_req && $stable(mem_rd))
        else $error("ctrl: memory request changed before accept");

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int unsigned SETS       = 64,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned IDX_W = $clog2(SETS),
    localparam int unsigned OFF_W = $clog2(LINE_WORDS) + icache_pkg::BYTE_OFF_W,
    localparam int unsigned TAG_W = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_req,
    input  icache_pkg::fetch_req_t fetch,
    output logic                   cpu_ack,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   flush_req,
    output logic                   flush_ack,
    output logic                   mem_req,
    output icache_pkg::mem_rd_t    mem_rd,
    input  logic                   mem_accept,
    input  logic                   mem_rvalid,
    input  logic                   mem_rlast,
    input  icache_pkg::word_t      mem_rdata
);

    logic                               rd_en;
    logic [IDX_W-1:0]                   rd_index;
    logic [TAG_W-1:0]                   rd_tag;
    logic [1:0]                         hit;
    icache_pkg::word_t [LINE_WORDS-1:0] rd_line0;
    icache_pkg::word_t [LINE_WORDS-1:0] rd_line1;
    icache_pkg::word_t [LINE_WORDS-1:0] fill_line;
    icache_pkg::word_t                  first_word;
    logic                               fill_start;
    logic                               fill_done;
    logic                               wr_en;
    logic [1:0]                         wr_way;
    logic [IDX_W-1:0]                   wr_index;
    logic [TAG_W-1:0]                   wr_tag;
    logic                               clr_en;
    logic [IDX_W-1:0]                   clr_index;
    logic                               lru_touch;
    logic [1:0]                         lru_way;
    logic [1:0]                         victim;

    icache_ctrl #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .fetch      (fetch),
        .cpu_ack    (cpu_ack),
        .rsp        (rsp),
        .flush_req  (flush_req),
        .flush_ack  (flush_ack),
        .mem_req    (mem_req),
        .mem_rd     (mem_rd),
        .mem_accept (mem_accept),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .rd_tag     (rd_tag),
        .hit        (hit),
        .rd_line0   (rd_line0),
        .rd_line1   (rd_line1),
        .fill_start (fill_start),
        .fill_line  (fill_line),
        .first_word (first_word),
        .fill_done  (fill_done),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .clr_en     (clr_en),
        .clr_index  (clr_index),
        .lru_touch  (lru_touch),
        .lru_way    (lru_way),
        .victim     (victim)
    );

    icache_tag_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tags (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_tag    (rd_tag),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .clr_en    (clr_en),
        .clr_index (clr_index),
        .hit       (hit)
    );

    icache_data_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_index (wr_index),
        .wr_line  (fill_line),
        .rd_line0 (rd_line0),
        .rd_line1 (rd_line1)
    );

    icache_refill_buffer #(.LINE_WORDS(LINE_WORDS)) u_refill (
        .clk        (clk),
        .rst        (rst),
        .start      (fill_start),
        .rvalid     (mem_rvalid),
        .rlast      (mem_rlast),
        .rdata      (mem_rdata),
        .line       (fill_line),
        .first_word (first_word),
        .fill_done  (fill_done)
    );

    icache_lru #(.SETS(SETS)) u_lru (
        .clk       (clk),
        .rst       (rst),
        .index     (rd_index),
        .touch     (lru_touch),
        .touch_way (lru_way),
        .clr_en    (clr_en),
        .clr_index (clr_index),
        .victim    (victim)
    );

endmodule

// File: sim/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

    localparam int unsigned SETS       = 64;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned OFF_W      = $clog2(LINE_WORDS) + 2;
    localparam int unsigned IDX_W      = $clog2(SETS);
    localparam int          TIMEOUT    = 200;   // cycles allowed per wait

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cpu_req;
    icache_pkg::fetch_req_t fetch;
    logic                   cpu_ack;
    icache_pkg::fetch_rsp_t rsp;
    logic                   flush_req;
    logic                   flush_ack;
    logic                   mem_req;
    icache_pkg::mem_rd_t    mem_rd;
    logic                   mem_accept;
    logic                   mem_rvalid;
    logic                   mem_rlast;
    icache_pkg::word_t      mem_rdata;

    icache_pkg::fetch_rsp_t exp_rsp;            // response of the fetch in flight
    icache_pkg::mem_rd_t    exp_rd;
    logic                   exp_mem;            // fetch should reach memory
    int                     mem_count;
    int                     error_count = 0;
    int                     check_count = 0;
    logic [31:0]            rng = 32'd31;
    logic                   ack_seen = 1'b0;
    logic                   timed_out = 1'b0;   // remaining steps are skipped

    logic [31:0] model_line  [2][SETS];         // line address per way
    logic        model_valid [2][SETS];
    logic        model_lru   [SETS];            // 1 when way 1 is least recent

    icache #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory content, a fixed mix of the word address
    function automatic icache_pkg::word_t model_word(input icache_pkg::addr_t addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic icache_pkg::fetch_rsp_t expected_rsp(input icache_pkg::addr_t pc);
        icache_pkg::fetch_rsp_t r;
        r.adef = pc[1:0] != 2'b00;
        r.data = r.adef ? '0 : model_word({pc[31:2], 2'b00});
        return r;
    endfunction

    // compares each response on the edge its ack is first seen
    always @(posedge clk) begin
        if (!rst && cpu_ack && !ack_seen) begin
            check_count++;
            assert (rsp.adef == exp_rsp.adef) else begin
                error_count++;
                $display("MISMATCH at %0t: rsp.adef = %0b, expected %0b",
                         $time, rsp.adef, exp_rsp.adef);
            end
            if (!exp_rsp.adef) begin
                assert (rsp.data == exp_rsp.data) else begin
                    error_count++;
                    $display("MISMATCH at %0t: rsp.data = %h, expected %h",
                             $time, rsp.data, exp_rsp.data);
                end
            end
        end
        ack_seen = cpu_ack;
    end

    initial begin : memory_model
        icache_pkg::mem_rd_t req;
        int                  beats;
        mem_accept <= 1'b0;
        mem_rvalid <= 1'b0;
        mem_rlast  <= 1'b0;
        mem_rdata  <= '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req) begin
                req = mem_rd;
                mem_count++;
                assert (exp_mem) else begin
                    error_count++;
                    $display("ERROR at %0t: memory request for a fetch that needs none", $time);
                end
                if (exp_mem) begin
                    assert (req.addr == exp_rd.addr) else begin
                        error_count++;
                        $display("MISMATCH at %0t: mem_rd.addr = %h, expected %h",
                                 $time, req.addr, exp_rd.addr);
                    end
                    assert (req.single == exp_rd.single) else begin
                        error_count++;
                        $display("MISMATCH at %0t: mem_rd.single = %0b, expected %0b",
                                 $time, req.single, exp_rd.single);
                    end
                end
                rng = xorshift(rng);
                repeat (rng[1:0]) @(posedge clk);      // 0 to 3 cycle accept delay
                mem_accept <= 1'b1;
                @(posedge clk);
                mem_accept <= 1'b0;
                beats = req.single ? 1 : LINE_WORDS;
                for (int i = 0; i < beats; i++) begin
                    mem_rvalid <= 1'b1;
                    mem_rlast  <= (i == beats - 1);
                    mem_rdata  <= model_word(req.addr + 32'(4 * i));
                    @(posedge clk);
                end
                mem_rvalid <= 1'b0;
                mem_rlast  <= 1'b0;
            end
        end
    end

    task automatic finish_run();
        $display("%0d responses checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        error_count++;
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
    endtask

    // edges counts posedges from the drive edge until the level is seen
    task automatic wait_cpu_ack(input logic level, output int edges);
        edges = 0;
        while (!timed_out && cpu_ack !== level) begin
            if (edges >= TIMEOUT) begin
                report_timeout("cpu_ack");
            end else begin
                @(posedge clk);
                edges++;
            end
        end
    endtask

    task automatic wait_flush_ack(input logic level);
        int n;
        n = 0;
        while (!timed_out && flush_ack !== level) begin
            if (n >= TIMEOUT) begin
                report_timeout("flush_ack");
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
    endtask

    task automatic expect_requests(input int n);
        if (!timed_out) begin
            assert (mem_count == n) else begin
                error_count++;
                $display("MISMATCH at %0t: memory requests = %0d, expected %0d",
                         $time, mem_count, n);
            end
        end
    endtask

    task automatic run_fetch(input icache_pkg::addr_t pc, input logic uncached);
        int unsigned set_idx;
        logic [31:0] line;
        int          way;
        int          victim;
        int          edges;
        if (timed_out) return;
        set_idx   = pc[OFF_W +: IDX_W];
        line      = pc >> OFF_W;
        way       = -1;
        exp_rsp   = expected_rsp(pc);
        exp_mem   = 1'b0;
        exp_rd    = '0;
        mem_count = 0;
        if (!exp_rsp.adef && uncached) begin
            exp_mem       = 1'b1;
            exp_rd.addr   = {pc[31:2], 2'b00};
            exp_rd.single = 1'b1;
        end else if (!exp_rsp.adef) begin
            for (int w = 0; w < 2; w++) begin
                if (model_valid[w][set_idx] && model_line[w][set_idx] == line) way = w;
            end
            if (way >= 0) begin
                model_lru[set_idx] = (way == 0);
            end else begin
                // an empty way first, then the least recent one
                victim = !model_valid[0][set_idx] ? 0 :
                         !model_valid[1][set_idx] ? 1 : model_lru[set_idx];
                model_valid[victim][set_idx] = 1'b1;
                model_line[victim][set_idx]  = line;
                model_lru[set_idx]           = (victim == 0);
                exp_mem     = 1'b1;
                exp_rd.addr = line << OFF_W;
            end
        end
        cpu_req        <= 1'b1;
        fetch.pc       <= pc;
        fetch.uncached <= uncached;
        wait_cpu_ack(1'b1, edges);
        if (timed_out) return;
        expect_requests(exp_mem ? 1 : 0);
        if (!exp_mem) begin
            // req sampled on the first edge, ack seen on the third
            assert (edges == 3) else begin
                error_count++;
                $display("MISMATCH at %0t: cpu_ack latency = %0d edges, expected 3",
                         $time, edges);
            end
        end
        cpu_req <= 1'b0;
        wait_cpu_ack(1'b0, edges);
    endtask

    task automatic run_flush();
        if (timed_out) return;
        exp_mem   = 1'b0;
        mem_count = 0;
        flush_req <= 1'b1;
        wait_flush_ack(1'b1);
        flush_req <= 1'b0;
        wait_flush_ack(1'b0);
        expect_requests(0);
        clear_model();
    endtask

    initial begin : stimulus
        icache_pkg::addr_t pc;
        clear_model();
        rst       <= 1'b1;
        cpu_req   <= 1'b0;
        fetch     <= '0;
        flush_req <= 1'b0;
        exp_rsp   = '0;
        exp_rd    = '0;
        exp_mem   = 1'b0;
        mem_count = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (cpu_ack === 1'b0 && flush_ack === 1'b0 && mem_req === 1'b0) else begin
            error_count++;
            $display("ERROR at %0t: handshake outputs not low after reset", $time);
        end

        run_fetch(32'h0000_0104, 1'b0);     // cold miss
        expect_requests(1);
        run_fetch(32'h0000_010c, 1'b0);     // same line, hit
        expect_requests(0);

        // set 5: A, B, A, C evicts B, then A hits and B misses
        run_fetch(32'h0000_1050, 1'b0);
        expect_requests(1);
        run_fetch(32'h0000_2054, 1'b0);
        expect_requests(1);
        run_fetch(32'h0000_1058, 1'b0);
        expect_requests(0);
        run_fetch(32'h0000_3050, 1'b0);
        expect_requests(1);
        run_fetch(32'h0000_105c, 1'b0);
        expect_requests(0);
        run_fetch(32'h0000_2050, 1'b0);
        expect_requests(1);

        run_fetch(32'h0000_0808, 1'b1);     // uncached word
        expect_requests(1);
        run_fetch(32'h0000_0804, 1'b0);     // line still absent
        expect_requests(1);

        run_fetch(32'h0000_0106, 1'b0);     // misaligned
        expect_requests(0);

        run_flush();
        run_fetch(32'h0000_0100, 1'b0);     // was resident before the flush
        expect_requests(1);

        // four tags over four sets keeps both hits and evictions frequent
        for (int n = 0; n < 200; n++) begin
            rng = xorshift(rng);
            pc  = 32'h0004_0000 | {rng[3:2], 10'h000} | {rng[5:4], 4'h0} | {rng[7:6], 2'b00};
            if (rng[12:9] == 4'd0) pc[0] = 1'b1;
            run_fetch(pc, rng[15:13] == 3'd0);
        end
        finish_run();
    end

endmodule

// File: verilog.f
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_refill_buffer.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache.sv
sim/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_tag_array.sv
  - logic/icache_data_array.sv
  - logic/icache_refill_buffer.sv
  - logic/icache_lru.sv
  - logic/icache_ctrl.sv
  - logic/icache.sv
  - target: simulation
    files:
      - sim/tb_icache.sv
